//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= div_cluster_tb
RTL_TOP   ?= div_cluster
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/div_cfg_pkg.sv
package div_cfg_pkg;

    localparam int XLEN      = 64;  // Operand and result width.
    localparam int NUM_LANES = 4;
    localparam int TAG_W     = 4;

    // One restoring step per quotient bit.
    localparam int DIV_ITERS = 64;

endpackage

//--- design/div_cluster.sv
`timescale 1ns/1ps

module div_cluster
    import div_op_pkg::*;
    import div_cfg_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    input  div_op_e          req_op,
    input  logic [XLEN-1:0]  req_a,
    input  logic [XLEN-1:0]  req_b,
    input  logic [TAG_W-1:0] req_tag,
    output logic             full,
    output logic             res_valid,
    output logic [XLEN-1:0]  res_data,
    output logic [TAG_W-1:0] res_tag
);

    logic [NUM_LANES-1:0]            start;
    logic [NUM_LANES-1:0]            release_lane;
    logic [NUM_LANES-1:0]            done;
    div_op_e                         lane_op;
    logic [XLEN-1:0]                 lane_a;
    logic [XLEN-1:0]                 lane_b;
    logic [TAG_W-1:0]                lane_tag;
    logic [NUM_LANES-1:0][XLEN-1:0]  lane_result;
    logic [NUM_LANES-1:0][TAG_W-1:0] lane_result_tag;

    div_dispatch div_dispatch_inst (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_op       (req_op),
        .req_a        (req_a),
        .req_b        (req_b),
        .req_tag      (req_tag),
        .release_lane (release_lane),
        .full         (full),
        .start        (start),
        .lane_op      (lane_op),
        .lane_a       (lane_a),
        .lane_b       (lane_b),
        .lane_tag     (lane_tag)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        div_lane div_lane_inst (
            .clk          (clk),
            .rst          (rst),
            .start        (start[i]),
            .op           (lane_op),
            .a            (lane_a),
            .b            (lane_b),
            .tag          (lane_tag),
            .release_lane (release_lane[i]),
            .done         (done[i]),
            .result       (lane_result[i]),
            .result_tag   (lane_result_tag[i])
        );
    end

    div_collect div_collect_inst (
        .clk          (clk),
        .rst          (rst),
        .done         (done),
        .lane_result  (lane_result),
        .lane_tag     (lane_result_tag),
        .release_lane (release_lane),
        .res_valid    (res_valid),
        .res_data     (res_data),
        .res_tag      (res_tag)
    );

endmodule

//--- design/div_collect.sv
`timescale 1ns/1ps

module div_collect
    import div_cfg_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic [NUM_LANES-1:0]            done,
    input  logic [NUM_LANES-1:0][XLEN-1:0]  lane_result,
    input  logic [NUM_LANES-1:0][TAG_W-1:0] lane_tag,
    output logic [NUM_LANES-1:0]            release_lane,
    output logic                            res_valid,
    output logic [XLEN-1:0]                 res_data,
    output logic [TAG_W-1:0]                res_tag
);

    logic [$clog2(NUM_LANES)-1:0] last_q;   // Previous winner.
    logic [$clog2(NUM_LANES)-1:0] idx;
    logic [$clog2(NUM_LANES)-1:0] win_idx;
    logic                         found;

    // Search starts just after the last winner and wraps.
    always_comb begin
        found        = 1'b0;
        win_idx      = last_q;
        idx          = last_q;
        release_lane = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            idx = idx + 1'b1;
            if (!found && done[idx]) begin
                found   = 1'b1;
                win_idx = idx;
            end
        end
        release_lane[win_idx] = found;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
            last_q    <= '1;  // Lane 0 has priority first.
        end else begin
            res_valid <= found;
            if (found) last_q <= win_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            res_data <= lane_result[win_idx];
            res_tag  <= lane_tag[win_idx];
        end
    end

endmodule

//--- design/div_dispatch.sv
`timescale 1ns/1ps

module div_dispatch
    import div_op_pkg::*;
    import div_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  div_op_e              req_op,
    input  logic [XLEN-1:0]      req_a,
    input  logic [XLEN-1:0]      req_b,
    input  logic [TAG_W-1:0]     req_tag,
    input  logic [NUM_LANES-1:0] release_lane,
    output logic                 full,
    output logic [NUM_LANES-1:0] start,
    output div_op_e              lane_op,
    output logic [XLEN-1:0]      lane_a,
    output logic [XLEN-1:0]      lane_b,
    output logic [TAG_W-1:0]     lane_tag
);

    logic [NUM_LANES-1:0] alloc;   // Lanes holding a request.
    logic [NUM_LANES-1:0] free;
    logic [NUM_LANES-1:0] pick;
    logic                 accept;

    assign free   = ~alloc;
    assign pick   = free & (~free + 1'b1);  // Lowest free lane.
    assign full   = &alloc;
    assign accept = req_valid & ~full;

    always_ff @(posedge clk) begin
        if (rst) begin
            alloc <= '0;
            start <= '0;
        end else begin
            start <= accept ? pick : '0;
            // A lane released this cycle cannot be the one picked.
            alloc <= (alloc & ~release_lane) | (accept ? pick : '0);
        end
    end

    // Broadcast to all lanes. Only the started one captures it.
    always_ff @(posedge clk) begin
        if (accept) begin
            lane_op  <= req_op;
            lane_a   <= req_a;
            lane_b   <= req_b;
            lane_tag <= req_tag;
        end
    end

endmodule

//--- design/div_lane.sv
`timescale 1ns/1ps

module div_lane
    import div_op_pkg::*;
    import div_cfg_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  div_op_e          op,
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    input  logic [TAG_W-1:0] tag,
    input  logic             release_lane,
    output logic             done,
    output logic [XLEN-1:0]  result,
    output logic [TAG_W-1:0] result_tag
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_CALC,
        ST_FIX,
        ST_HOLD
    } state_e;

    state_e                       state;
    logic [$clog2(DIV_ITERS)-1:0] iter;
    div_op_e                      op_q;
    logic [XLEN-1:0]              a_in;
    logic [XLEN-1:0]              b_in;
    logic [XLEN-1:0]              a_ext;  // Operands after W extension.
    logic [XLEN-1:0]              b_ext;
    logic [XLEN-1:0]              b_mag;
    logic                         a_neg;
    logic                         b_neg;
    logic                         q_neg;
    logic                         r_neg;
    logic [2*XLEN:0]              work;   // {partial remainder, quotient}.
    logic [2*XLEN:0]              shifted;
    logic [2*XLEN:0]              step;
    logic [XLEN:0]                diff;
    logic                         div_zero;
    logic                         overflow;
    logic [XLEN-1:0]              q_fix;
    logic [XLEN-1:0]              r_fix;
    logic [XLEN-1:0]              sel;
    logic [XLEN-1:0]              fix_result;

    // W ops keep the low word, extended as the op requires.
    always_comb begin
        a_in = a;
        b_in = b;
        if (op_is_word(op)) begin
            if (op_is_signed(op)) begin
                a_in = {{(XLEN-32){a[31]}}, a[31:0]};
                b_in = {{(XLEN-32){b[31]}}, b[31:0]};
            end else begin
                a_in = {{(XLEN-32){1'b0}}, a[31:0]};
                b_in = {{(XLEN-32){1'b0}}, b[31:0]};
            end
        end
    end

    assign a_neg = op_is_signed(op_q) & a_ext[XLEN-1];
    assign b_neg = op_is_signed(op_q) & b_ext[XLEN-1];

    // One restoring shift-subtract step.
    always_comb begin
        shifted = {work[2*XLEN-1:0], 1'b0};
        diff    = shifted[2*XLEN:XLEN] - {1'b0, b_mag};
        step    = shifted;
        if (shifted[2*XLEN:XLEN] >= {1'b0, b_mag}) begin
            step = {diff, shifted[XLEN-1:1], 1'b1};
        end
    end

    always_comb begin
        div_zero = (b_ext == '0);
        if (op_is_word(op_q)) begin
            overflow = (a_ext == {{(XLEN-31){1'b1}}, 31'b0});
        end else begin
            overflow = (a_ext == {1'b1, {(XLEN-1){1'b0}}});
        end
        overflow = overflow && op_is_signed(op_q) && (b_ext == '1);

        q_fix = q_neg ? -work[XLEN-1:0] : work[XLEN-1:0];
        r_fix = r_neg ? -work[2*XLEN-1:XLEN] : work[2*XLEN-1:XLEN];
        if (div_zero) begin
            q_fix = '1;
            r_fix = a_ext;
        end else if (overflow) begin
            q_fix = a_ext;
            r_fix = '0;
        end

        sel = op_is_rem(op_q) ? r_fix : q_fix;
        fix_result = op_is_word(op_q) ? {{(XLEN-32){sel[31]}}, sel[31:0]} : sel;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            done  <= 1'b0;
            iter  <= '0;
        end else begin
            case (state)
                ST_IDLE: if (start) state <= ST_LOAD;
                ST_LOAD: begin
                    iter  <= '0;
                    state <= ST_CALC;
                end
                ST_CALC: begin
                    iter <= iter + 1'b1;
                    if (iter == ($clog2(DIV_ITERS))'(DIV_ITERS - 1)) state <= ST_FIX;
                end
                ST_FIX: begin
                    done  <= 1'b1;
                    state <= ST_HOLD;
                end
                ST_HOLD: begin
                    if (release_lane) begin  // Result taken by the collector.
                        done  <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (start) begin
                    op_q       <= op;
                    a_ext      <= a_in;
                    b_ext      <= b_in;
                    result_tag <= tag;
                end
            end
            ST_LOAD: begin
                work  <= {{(XLEN+1){1'b0}}, (a_neg ? -a_ext : a_ext)};
                b_mag <= b_neg ? -b_ext : b_ext;
                q_neg <= a_neg ^ b_neg;
                r_neg <= a_neg;  // Remainder follows the dividend.
            end
            ST_CALC: work <= step;
            ST_FIX:  result <= fix_result;
            default: ;
        endcase
    end

endmodule

//--- design/div_op_pkg.sv
package div_op_pkg;

    // Decoded M-extension divide operations.
    typedef enum logic [2:0] {
        DIV,
        DIVU,
        REM,
        REMU,
        DIVW,
        DIVUW,
        REMW,
        REMUW
    } div_op_e;

    // Operands are treated as two's complement.
    function automatic logic op_is_signed(div_op_e op);
        return op inside {DIV, REM, DIVW, REMW};
    endfunction

    // Result is the remainder, not the quotient.
    function automatic logic op_is_rem(div_op_e op);
        return op inside {REM, REMU, REMW, REMUW};
    endfunction

    // 32-bit operation with a sign-extended result.
    function automatic logic op_is_word(div_op_e op);
        return op inside {DIVW, DIVUW, REMW, REMUW};
    endfunction

endpackage

//--- sim/div_model.svh
`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

// Expected RISC-V M-extension divide result for one request.
function automatic logic [XLEN-1:0] div_ref(div_op_e op, logic [XLEN-1:0] a,
                                            logic [XLEN-1:0] b);
    logic [XLEN-1:0] x;
    logic [XLEN-1:0] y;
    logic [XLEN-1:0] q;
    logic [XLEN-1:0] r;
    logic [XLEN-1:0] res;
    x = a;
    y = b;
    if (op_is_word(op)) begin  // Only the low words count.
        if (op_is_signed(op)) begin
            x = {{(XLEN-32){a[31]}}, a[31:0]};
            y = {{(XLEN-32){b[31]}}, b[31:0]};
        end else begin
            x = {{(XLEN-32){1'b0}}, a[31:0]};
            y = {{(XLEN-32){1'b0}}, b[31:0]};
        end
    end
    if (y == '0) begin
        q = '1;
        r = x;
    end else if (op_is_signed(op) && !op_is_word(op) && x == MIN_VAL && y == '1) begin
        q = x;  // Signed overflow.
        r = '0;
    end else if (op_is_signed(op)) begin
        // Truncating division with the remainder taking the dividend's sign.
        q = $signed(x) / $signed(y);
        r = $signed(x) % $signed(y);
    end else begin
        q = x / y;
        r = x % y;
    end
    res = op_is_rem(op) ? r : q;
    if (op_is_word(op)) begin
        res = {{(XLEN-32){res[31]}}, res[31:0]};
    end
    return res;
endfunction

`endif

//--- sim/div_cluster_tb.sv
`timescale 1ns/1ps

module div_cluster_tb
    import div_op_pkg::*;
    import div_cfg_pkg::*;
();

    localparam logic [31:0]     SEED        = 32'h37c2_ba4c;
    localparam int              NUM_REQS    = 80 + 30 + 42 + 48;  // Requests over all tests.
    localparam int              TIMEOUT     = NUM_REQS * (DIV_ITERS + 6) + 200;
    localparam int              RESULT_WAIT = 2 * (DIV_ITERS + 6);
    localparam logic [XLEN-1:0] MIN_VAL     = {1'b1, {(XLEN-1){1'b0}}};

    logic             clk = 1'b0;
    logic             rst;
    logic             req_valid;
    div_op_e          req_op;
    logic [XLEN-1:0]  req_a;
    logic [XLEN-1:0]  req_b;
    logic [TAG_W-1:0] req_tag;
    logic             full;
    logic             res_valid;
    logic [XLEN-1:0]  res_data;
    logic [TAG_W-1:0] res_tag;

    logic [XLEN-1:0]  exp_data [2**TAG_W];  // Scoreboard indexed by tag.
    bit               outstanding [2**TAG_W];
    logic [TAG_W-1:0] next_tag = '0;
    int               pending = 0;
    int               errors = 0;
    int               errors_at_start = 0;
    int               tests_passed = 0;
    int               tests_failed = 0;
    int               cycles = 0;
    int               seed_val;
    bit               saw_full;
    string            cur_test;

    `include "div_model.svh"

    div_cluster div_cluster_inst (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_a     (req_a),
        .req_b     (req_b),
        .req_tag   (req_tag),
        .full      (full),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_tag   (res_tag)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Run timed out after %0d cycles with %0d results outstanding",
                     cycles, pending);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_data(logic [TAG_W-1:0] tag, logic [XLEN-1:0] exp,
                              logic [XLEN-1:0] act);
        if (act !== exp) begin
            errors = errors + 1;
            $display("mismatch %s tag %0d: expected %h, actual %h", cur_test, tag, exp, act);
        end
    endtask

    // Returning tags must be outstanding. None may be left at the end of a test.
    task automatic check_tag(logic [TAG_W-1:0] tag, bit returning);
        if (returning && !outstanding[tag]) begin
            errors = errors + 1;
            $display("Error in %s: tag %0d returned while not outstanding", cur_test, tag);
        end else if (!returning && outstanding[tag]) begin
            errors = errors + 1;
            $display("Error in %s: tag %0d never returned", cur_test, tag);
        end
    endtask

    always @(negedge clk) begin
        if (!rst && res_valid) begin
            check_tag(res_tag, 1'b1);
            if (outstanding[res_tag]) begin
                check_data(res_tag, exp_data[res_tag], res_data);
                outstanding[res_tag] = 1'b0;
                pending = pending - 1;
            end
        end
    end

    // Returns at the falling edge before the edge that takes the request.
    task automatic send(div_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        @(posedge clk);
        req_valid <= 1'b1;
        req_op    <= op;
        req_a     <= a;
        req_b     <= b;
        req_tag   <= next_tag;
        @(negedge clk);
        while (full) begin
            saw_full = 1'b1;
            if (pending < NUM_LANES) begin
                errors = errors + 1;
                $display("Error in %s: full high with %0d requests in flight",
                         cur_test, pending);
            end
            @(negedge clk);
        end
        if (outstanding[next_tag]) begin
            errors = errors + 1;
            $display("Error in %s: tag %0d reused before it returned", cur_test, next_tag);
        end
        exp_data[next_tag]    = div_ref(op, a, b);
        outstanding[next_tag] = 1'b1;
        pending               = pending + 1;
        next_tag              = next_tag + 1'b1;
    endtask

    // Waits for the results in flight, at most RESULT_WAIT cycles.
    task automatic wait_idle();
        int waited;
        waited = 0;
        while (pending != 0 && waited < RESULT_WAIT) begin
            @(negedge clk);
            waited = waited + 1;
        end
    endtask

    task automatic send_alone(div_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        send(op, a, b);
        @(posedge clk);
        req_valid <= 1'b0;
        wait_idle();
    endtask

    task automatic begin_test(string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        wait_idle();
        for (int t = 0; t < 2**TAG_W; t++) begin
            check_tag(TAG_W'(t), 1'b0);
            if (outstanding[t]) begin  // Lost result, dropped so the next test starts clean.
                outstanding[t] = 1'b0;
                pending        = pending - 1;
            end
        end
        if (errors == errors_at_start) begin
            tests_passed = tests_passed + 1;
            $display("PASS %s", cur_test);
        end else begin
            tests_failed = tests_failed + 1;
            $display("FAIL %s with %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        div_op_e         word_ops [4];
        word_ops  = '{DIVW, DIVUW, REMW, REMUW};
        seed_val  = $urandom(SEED);
        rst       = 1'b1;
        req_valid = 1'b0;
        req_op    = DIV;
        req_a     = '0;
        req_b     = '0;
        req_tag   = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        begin_test("idle after reset");
        repeat (20) begin
            @(negedge clk);
            if (full !== 1'b0 || res_valid !== 1'b0) begin
                errors = errors + 1;
                $display("Error in %s: full or res_valid high with no request", cur_test);
            end
        end
        end_test();

        begin_test("unsigned DIVU and REMU");
        for (int i = 0; i < 40; i++) begin
            a = {$urandom, $urandom};
            b = {$urandom, $urandom} >> $urandom_range(0, 63);
            send_alone(DIVU, a, b);
            send_alone(REMU, a, b);
        end
        end_test();

        begin_test("signed DIV and REM");
        for (int s = 0; s < 4; s++) begin  // Every sign combination.
            a = {$urandom, $urandom} >> 1;
            b = ({32'b0, $urandom} >> $urandom_range(0, 28)) | 64'd1;
            a = s[1] ? -a : a;
            b = s[0] ? -b : b;
            send_alone(DIV, a, b);
            send_alone(REM, a, b);
        end
        send_alone(DIV, MIN_VAL, '1);
        send_alone(REM, MIN_VAL, '1);
        a = {$urandom, $urandom};
        send_alone(DIV, a, '0);
        send_alone(REM, a, '0);
        send_alone(DIVU, a, '0);
        send_alone(REMU, a, '0);
        for (int i = 0; i < 8; i++) begin
            a = {$urandom, $urandom};
            b = {$urandom, $urandom} >> $urandom_range(0, 63);
            send_alone(DIV, a, b);
            send_alone(REM, a, b);
        end
        end_test();

        begin_test("word DIVW DIVUW REMW REMUW");
        for (int i = 0; i < 40; i++) begin
            a = {$urandom, $urandom};  // Upper words are garbage.
            b = {$urandom, $urandom >> $urandom_range(0, 28)};
            send_alone(word_ops[i % 4], a, b);
        end
        a = {$urandom, 32'h8000_0000};
        b = {$urandom, 32'hffff_ffff};
        send_alone(DIVW, a, b);
        send_alone(REMW, a, b);
        end_test();

        begin_test("mixed burst");
        saw_full = 1'b0;
        for (int i = 0; i < 48; i++) begin
            a = {$urandom, $urandom};
            b = {$urandom, $urandom} >> $urandom_range(0, 63);
            send(div_op_e'(3'($urandom_range(0, 7))), a, b);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        if (!saw_full) begin
            errors = errors + 1;
            $display("Error in %s: full never rose with all lanes busy", cur_test);
        end
        end_test();

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+sim
design/div_op_pkg.sv
design/div_cfg_pkg.sv
design/div_dispatch.sv
design/div_lane.sv
design/div_collect.sv
design/div_cluster.sv
sim/div_cluster_tb.sv
